// ==== conv_pkg.sv ====
package conv_pkg;

	typedef logic [7:0] pixel_t;
	typedef logic signed [7:0] coef_t;

	// valid travels beside the request
	typedef struct packed {
		logic [31:0] addr;
		logic        we;
		logic [31:0] wdata;
	} mem_req_t;

	typedef struct packed {
		logic [15:0] width;	// upper half
		logic [15:0] height;
	} cfg_dims_t;

	typedef union packed {
		cfg_dims_t   dims;
		coef_t [3:0] coefs;	// coefs[0] in the low byte
	} cfg_word_u;

	// coefs[r*3+c], row r from the top, column c from the left
	typedef struct packed {
		logic [15:0] width;
		logic [15:0] height;
		logic [31:0] src_addr;
		logic [31:0] dst_addr;
		coef_t [8:0] coefs;
	} conv_cfg_t;

	typedef struct packed {
		pixel_t top;
		pixel_t mid;
		pixel_t bot;
	} pixel_col_t;

	localparam logic [2:0] OFS_START = 3'd0;
	localparam logic [2:0] OFS_DIMS  = 3'd1;
	localparam logic [2:0] OFS_SRC   = 3'd2;
	localparam logic [2:0] OFS_DST   = 3'd3;
	localparam logic [2:0] OFS_COEF0 = 3'd4;
	localparam logic [2:0] OFS_COEF1 = 3'd5;
	localparam logic [2:0] OFS_COEF2 = 3'd6;	// low byte only

endpackage

// ==== conv_config_loader.sv ====
`timescale 1ns/10ps

module conv_config_loader #(
	parameter logic [31:0] CONFIG_BASE = 32'h0000_0100
) (
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic                 cfg_start,
	output logic                 ld_valid,
	output conv_pkg::mem_req_t   ld_req,
	input  logic                 ld_ready,
	input  logic                 rsp_valid,
	input  conv_pkg::cfg_word_u  rsp_data,
	output conv_pkg::conv_cfg_t  cfg,
	output logic                 cfg_done
);
	import conv_pkg::*;

	logic [2:0] idx;
	logic       busy;
	logic       rsp_take;

	assign ld_req   = '{addr: CONFIG_BASE + 32'(idx), we: 1'b0, wdata: 32'd0};
	assign rsp_take = busy && !ld_valid && rsp_valid;	// read accepted, word back

	always_ff @(posedge clk, negedge rst_n) begin
		if (!rst_n) begin
			busy     <= 1'b0;
			ld_valid <= 1'b0;
			idx      <= OFS_DIMS;
			cfg_done <= 1'b0;
		end else begin
			cfg_done <= 1'b0;
			if (cfg_start) begin
				busy     <= 1'b1;
				idx      <= OFS_DIMS;
				ld_valid <= 1'b1;
			end else if (ld_valid && ld_ready) begin
				ld_valid <= 1'b0;
			end else if (rsp_take) begin
				if (idx == OFS_COEF2) begin
					busy     <= 1'b0;
					cfg_done <= 1'b1;
				end else begin
					idx      <= idx + 3'd1;
					ld_valid <= 1'b1;	// next word
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (rsp_take) begin
			case (idx)
				OFS_DIMS: begin
					cfg.width  <= rsp_data.dims.width;
					cfg.height <= rsp_data.dims.height;
				end
				OFS_SRC:   cfg.src_addr    <= rsp_data;
				OFS_DST:   cfg.dst_addr    <= rsp_data;
				OFS_COEF0: cfg.coefs[3:0]  <= rsp_data.coefs;
				OFS_COEF1: cfg.coefs[7:4]  <= rsp_data.coefs;
				OFS_COEF2: cfg.coefs[8]    <= rsp_data.coefs[0];
				default: ;
			endcase
		end
	end

endmodule

// ==== conv_controller.sv ====
`timescale 1ns/10ps

module conv_controller #(
	parameter logic [31:0] CONFIG_BASE = 32'h0000_0100,
	parameter int          MAX_WIDTH   = 64
) (
	input  logic                          clk,
	input  logic                          rst_n,
	output logic                          mem_valid,
	output conv_pkg::mem_req_t            mem_req,
	input  logic                          mem_ready,
	input  logic                          rsp_valid,
	input  logic [31:0]                   rsp_data,
	input  logic                          ld_valid,
	input  conv_pkg::mem_req_t            ld_req,
	output logic                          ld_ready,
	output logic                          cfg_start,
	input  logic                          cfg_done,
	input  conv_pkg::conv_cfg_t           cfg,
	output logic                          wr_en,
	output logic [1:0]                    wr_slot,
	output logic [$clog2(MAX_WIDTH)-1:0]  wr_col,
	output logic                          rd_en,
	output logic [$clog2(MAX_WIDTH)-1:0]  rd_col,
	output logic [1:0]                    top_slot,
	output logic                          row_start,
	input  logic                          col_ready,
	input  logic                          res_valid,
	input  conv_pkg::pixel_t              res,
	output logic                          res_ready,
	output logic                          done
);
	import conv_pkg::*;

	localparam int CW = $clog2(MAX_WIDTH);

	typedef enum logic [2:0] {
		S_POLL, S_LOAD, S_FILL, S_SWEEP, S_DRAIN, S_FETCH, S_ROTATE, S_DONE
	} state_e;

	state_e        state, next;
	logic          rd_req, rd_wait, rsp_ok, wr_phase, res_acc;
	logic [31:0]   rd_addr, wr_addr;
	logic [15:0]   rows_left;	// rows still to fetch
	logic [CW-1:0] last_col, last_res, res_cnt;

	assign last_col  = CW'(cfg.width - 16'd1);
	assign last_res  = CW'(cfg.width - 16'd3);
	assign wr_phase  = (state == S_SWEEP) || (state == S_DRAIN);
	assign rsp_ok    = rsp_valid && rd_wait;
	assign wr_en     = rsp_ok && ((state == S_FILL) || (state == S_FETCH));
	assign rd_en     = (state == S_SWEEP) && col_ready;
	assign res_ready = wr_phase && mem_ready;
	assign res_acc   = res_valid && res_ready;
	assign ld_ready  = (state == S_LOAD) && mem_ready;
	assign row_start = !wr_phase;	// filter is empty outside a sweep
	assign done      = (state == S_DONE);

	// port arbitration
	always_comb begin
		mem_valid = rd_req;
		mem_req   = '{addr: rd_addr, we: 1'b0, wdata: 32'd0};
		case (state)
			S_POLL: mem_req.addr = CONFIG_BASE + 32'(OFS_START);
			S_LOAD: begin
				mem_valid = ld_valid;
				mem_req   = ld_req;
			end
			S_SWEEP, S_DRAIN: begin
				mem_valid = res_valid;
				mem_req   = '{addr: wr_addr, we: 1'b1, wdata: {24'd0, res}};
			end
			default: ;
		endcase
	end

	always_comb begin
		next = state;
		case (state)
			S_POLL:   if (rsp_ok && rsp_data == 32'd1) next = S_LOAD;
			S_LOAD:   if (cfg_done) next = S_FILL;
			S_FILL:   if (wr_en && wr_col == last_col && wr_slot == 2'd2) next = S_SWEEP;
			S_SWEEP:  if (rd_en && rd_col == last_col) next = S_DRAIN;
			S_DRAIN:  if (res_acc && res_cnt == last_res)
				next = (rows_left == 16'd0) ? S_DONE : S_FETCH;
			S_FETCH:  if (wr_en && wr_col == last_col) next = S_ROTATE;
			S_ROTATE: next = S_SWEEP;
			S_DONE:   next = S_POLL;
			default:  next = S_POLL;
		endcase
	end

	always_ff @(posedge clk, negedge rst_n) begin
		if (!rst_n) begin
			state     <= S_POLL;
			rd_req    <= 1'b0;
			rd_wait   <= 1'b0;
			cfg_start <= 1'b0;
			rd_addr   <= '0;
			wr_addr   <= '0;
			rows_left <= '0;
			top_slot  <= '0;
			wr_slot   <= '0;
			wr_col    <= '0;
			rd_col    <= '0;
			res_cnt   <= '0;
		end else begin
			state     <= next;
			cfg_start <= (state == S_POLL) && (next == S_LOAD);

			// single outstanding read
			if (rd_req && mem_ready) begin
				rd_req  <= 1'b0;
				rd_wait <= 1'b1;
				if (state != S_POLL)
					rd_addr <= rd_addr + 32'd1;
			end else if (rsp_ok) begin
				rd_wait <= 1'b0;
			end else if (!rd_req && !rd_wait &&
			             (state == S_POLL || state == S_FILL || state == S_FETCH)) begin
				rd_req <= 1'b1;
			end

			if (cfg_done) begin
				rd_addr   <= cfg.src_addr;
				wr_addr   <= cfg.dst_addr;
				rows_left <= cfg.height - 16'd3;
				top_slot  <= 2'd0;
				wr_slot   <= 2'd0;
				wr_col    <= '0;
			end

			if (wr_en) begin
				if (wr_col == last_col) begin
					wr_col  <= '0;
					wr_slot <= wr_slot + 2'd1;
				end else begin
					wr_col <= wr_col + 1'b1;
				end
			end

			if (!wr_phase) begin
				rd_col  <= '0;
				res_cnt <= '0;
			end else begin
				if (rd_en)
					rd_col <= rd_col + 1'b1;
				if (res_acc) begin
					res_cnt <= res_cnt + 1'b1;
					wr_addr <= wr_addr + 32'd1;
				end
			end

			if (state == S_DRAIN && next == S_FETCH)
				wr_slot <= top_slot;	// oldest row gets overwritten
			if (state == S_ROTATE) begin
				top_slot  <= (top_slot == 2'd2) ? 2'd0 : top_slot + 2'd1;
				rows_left <= rows_left - 16'd1;
			end
		end
	end

endmodule

// ==== line_buffer.sv ====
`timescale 1ns/10ps

module line_buffer #(
	parameter int MAX_WIDTH = 64
) (
	input  logic                          clk,
	input  logic                          rst_n,
	input  logic                          wr_en,
	input  logic [1:0]                    wr_slot,
	input  logic [$clog2(MAX_WIDTH)-1:0]  wr_col,
	input  conv_pkg::pixel_t              wr_data,
	input  logic                          rd_en,
	input  logic [$clog2(MAX_WIDTH)-1:0]  rd_col,
	input  logic [1:0]                    top_slot,
	output logic                          col_valid,
	output conv_pkg::pixel_col_t          col,
	input  logic                          col_ready
);
	import conv_pkg::*;

	pixel_t     rows [3][MAX_WIDTH];
	logic [1:0] mid_slot, bot_slot;

	// slots follow top_slot round the ring
	assign mid_slot = (top_slot == 2'd2) ? 2'd0 : top_slot + 2'd1;
	assign bot_slot = (top_slot == 2'd0) ? 2'd2 : top_slot - 2'd1;

	always_ff @(posedge clk) begin
		if (wr_en)
			rows[wr_slot][wr_col] <= wr_data;
		if (rd_en) begin
			col.top <= rows[top_slot][rd_col];
			col.mid <= rows[mid_slot][rd_col];
			col.bot <= rows[bot_slot][rd_col];
		end
	end

	// rd_en only comes with col_ready, so col holds otherwise
	always_ff @(posedge clk, negedge rst_n) begin
		if (!rst_n)
			col_valid <= 1'b0;
		else if (rd_en)
			col_valid <= 1'b1;
		else if (col_ready)
			col_valid <= 1'b0;
	end

endmodule

// ==== filter_mac.sv ====
`timescale 1ns/10ps

module filter_mac (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  col_valid,
	input  conv_pkg::pixel_col_t  col,
	output logic                  col_ready,
	input  conv_pkg::coef_t [8:0] coefs,
	output logic                  res_valid,
	output conv_pkg::pixel_t      res,
	input  logic                  res_ready,
	input  logic                  row_start
);
	import conv_pkg::*;

	pixel_col_t         win1, win0;	// win1 is the oldest column
	pixel_col_t         wcol [3];
	pixel_t             pix [9];
	logic signed [16:0] prod [9];
	logic signed [20:0] sum;
	logic [1:0]         ncols;
	logic               take, p_valid;

	assign col_ready = !(res_valid && !res_ready);
	assign take      = col_valid && col_ready;

	// window in raster order, incoming column on the right
	always_comb begin
		wcol[0] = win1;
		wcol[1] = win0;
		wcol[2] = col;
		for (int c = 0; c < 3; c++) begin
			pix[c]     = wcol[c].top;
			pix[c + 3] = wcol[c].mid;
			pix[c + 6] = wcol[c].bot;
		end
	end

	always_comb begin
		sum = '0;
		for (int k = 0; k < 9; k++)
			sum = sum + prod[k];
	end

	always_ff @(posedge clk, negedge rst_n) begin
		if (!rst_n) begin
			ncols     <= '0;
			p_valid   <= 1'b0;
			res_valid <= 1'b0;
		end else begin
			if (row_start)
				ncols <= '0;
			else if (take && ncols != 2'd2)
				ncols <= ncols + 2'd1;
			if (col_ready) begin
				p_valid   <= take && (ncols == 2'd2);
				res_valid <= p_valid;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (take) begin
			win1 <= win0;
			win0 <= col;
		end
		if (col_ready) begin
			for (int k = 0; k < 9; k++)
				prod[k] <= $signed({1'b0, pix[k]}) * coefs[k];
			if (sum < 0)
				res <= 8'd0;
			else if (sum > 21'sd255)
				res <= 8'd255;	// clamp high
			else
				res <= sum[7:0];
		end
	end

endmodule

// ==== conv_top.sv ====
`timescale 1ns/10ps

module conv_top #(
	parameter logic [31:0] CONFIG_BASE = 32'h0000_0100,
	parameter int          MAX_WIDTH   = 64
) (
	input  logic               clk,
	input  logic               rst_n,
	output logic               mem_valid,
	output conv_pkg::mem_req_t mem_req,
	input  logic               mem_ready,
	input  logic               rsp_valid,
	input  logic [31:0]        rsp_data,
	output logic               done
);
	import conv_pkg::*;

	localparam int CW = $clog2(MAX_WIDTH);

	logic       ld_valid, ld_ready, cfg_start, cfg_done;
	mem_req_t   ld_req;
	conv_cfg_t  cfg;
	logic       wr_en, rd_en, row_start;
	logic [1:0] wr_slot, top_slot;
	logic [CW-1:0] wr_col, rd_col;
	logic       col_valid, col_ready, res_valid, res_ready;
	pixel_col_t col;
	pixel_t     res;

	conv_config_loader #(
		.CONFIG_BASE(CONFIG_BASE)
	) u_loader (
		.clk      (clk),
		.rst_n    (rst_n),
		.cfg_start(cfg_start),
		.ld_valid (ld_valid),
		.ld_req   (ld_req),
		.ld_ready (ld_ready),
		.rsp_valid(rsp_valid),
		.rsp_data (rsp_data),
		.cfg      (cfg),
		.cfg_done (cfg_done)
	);

	conv_controller #(
		.CONFIG_BASE(CONFIG_BASE),
		.MAX_WIDTH  (MAX_WIDTH)
	) u_ctrl (
		.clk      (clk),
		.rst_n    (rst_n),
		.mem_valid(mem_valid),
		.mem_req  (mem_req),
		.mem_ready(mem_ready),
		.rsp_valid(rsp_valid),
		.rsp_data (rsp_data),
		.ld_valid (ld_valid),
		.ld_req   (ld_req),
		.ld_ready (ld_ready),
		.cfg_start(cfg_start),
		.cfg_done (cfg_done),
		.cfg      (cfg),
		.wr_en    (wr_en),
		.wr_slot  (wr_slot),
		.wr_col   (wr_col),
		.rd_en    (rd_en),
		.rd_col   (rd_col),
		.top_slot (top_slot),
		.row_start(row_start),
		.col_ready(col_ready),
		.res_valid(res_valid),
		.res      (res),
		.res_ready(res_ready),
		.done     (done)
	);

	line_buffer #(
		.MAX_WIDTH(MAX_WIDTH)
	) u_lbuf (
		.clk      (clk),
		.rst_n    (rst_n),
		.wr_en    (wr_en),
		.wr_slot  (wr_slot),
		.wr_col   (wr_col),
		.wr_data  (rsp_data[7:0]),	// pixel in the low byte
		.rd_en    (rd_en),
		.rd_col   (rd_col),
		.top_slot (top_slot),
		.col_valid(col_valid),
		.col      (col),
		.col_ready(col_ready)
	);

	filter_mac u_mac (
		.clk      (clk),
		.rst_n    (rst_n),
		.col_valid(col_valid),
		.col      (col),
		.col_ready(col_ready),
		.coefs    (cfg.coefs),
		.res_valid(res_valid),
		.res      (res),
		.res_ready(res_ready),
		.row_start(row_start)
	);

endmodule

// ==== tb_conv.sv ====
`timescale 1ns/10ps

module tb_conv;
	import conv_pkg::*;

	localparam logic [31:0] CONFIG_BASE = 32'h0000_0100;
	localparam int          MAX_WIDTH   = 64;

	logic        clk, rst_n, mem_ready, rsp_valid, mem_valid, done;
	logic [31:0] rsp_data, rd_data;
	mem_req_t    mem_req, held_req;
	logic [67:0] recs [0:63];	// kind, addr, data
	logic [31:0] mem [int unsigned];
	logic [31:0] exp_addr [$];
	pixel_t      exp_pix [$];
	logic        run_active, run_done, stall_mode, was_stalled;
	int          rsp_cnt;

	conv_top #(
		.CONFIG_BASE(CONFIG_BASE),
		.MAX_WIDTH  (MAX_WIDTH)
	) u_conv_top (
		.clk      (clk),
		.rst_n    (rst_n),
		.mem_valid(mem_valid),
		.mem_req  (mem_req),
		.mem_ready(mem_ready),
		.rsp_valid(rsp_valid),
		.rsp_data (rsp_data),
		.done     (done)
	);

	always #50 clk = ~clk;

	task automatic fail_run(input string what);
		$display("%0t: %s", $time, what);
		$display("TESTS FAILED");
		$fatal(1);
	endtask

	task automatic check_write(input logic [31:0] addr, input pixel_t exp, input mem_req_t act);
		if (act.addr !== addr || act.wdata !== {24'd0, exp}) begin
			$display("error %0t: mem_req expected addr %h data %h, got addr %h data %h",
			         $time, addr, exp, act.addr, act.wdata);
			$display("TESTS FAILED");
			$fatal(1);
		end
	endtask

	task automatic check_done(input logic exp, input logic act);
		if (exp !== act) begin
			$display("error %0t: done expected %b, got %b", $time, exp, act);
			$display("TESTS FAILED");
			$fatal(1);
		end
	endtask

	task automatic check_req(input mem_req_t exp, input mem_req_t act);
		if (exp !== act) begin
			$display("error %0t: mem_req under stall expected %h, got %h", $time, exp, act);
			$display("TESTS FAILED");
			$fatal(1);
		end
	endtask

	// low byte xor'd with the upper bytes
	function automatic pixel_t fill_pixel(input logic [31:0] a);
		return pixel_t'((a * 32'd97) ^ (a >> 8) ^ (a >> 16) ^ (a >> 24));
	endfunction

	function automatic logic [31:0] rd_mem(input logic [31:0] a);
		return mem.exists(a) ? mem[a] : 32'd0;
	endfunction

	// reference convolution over the valid region
	task automatic build_expected();
		logic [31:0] dims, src, dst, cw;
		coef_t       k [9];
		pixel_t      p;
		int          w, h, sum;
		dims = rd_mem(CONFIG_BASE + 1);
		src  = rd_mem(CONFIG_BASE + 2);
		dst  = rd_mem(CONFIG_BASE + 3);
		w    = int'(dims[31:16]);
		h    = int'(dims[15:0]);
		for (int i = 0; i < 9; i++) begin
			cw   = rd_mem(CONFIG_BASE + 4 + i / 4);
			k[i] = coef_t'(cw >> (8 * (i % 4)));
		end
		for (int r = 0; r < h - 2; r++) begin
			for (int c = 0; c < w - 2; c++) begin
				sum = 0;
				for (int i = 0; i < 3; i++) begin
					for (int j = 0; j < 3; j++) begin
						p   = pixel_t'(rd_mem(src + (r + i) * w + c + j));
						sum = sum + int'(k[i * 3 + j]) * int'(p);
					end
				end
				exp_addr.push_back(dst + r * (w - 2) + c);
				exp_pix.push_back(sum < 0 ? 8'd0 : (sum > 255 ? 8'd255 : pixel_t'(sum)));
			end
		end
	endtask

	// memory model and bus monitor
	initial begin
		void'($urandom(32));
		forever begin
			@(posedge clk);
			if (!rst_n) begin
				if (mem_valid !== 1'b0)
					fail_run("mem_valid is high during reset");
				check_done(1'b0, done);
			end else begin
				rsp_valid <= 1'b0;
				if (was_stalled) begin
					if (mem_valid !== 1'b1)
						fail_run("a stalled request was withdrawn");
					check_req(held_req, mem_req);
				end
				was_stalled = mem_valid && !mem_ready;
				held_req    = mem_req;
				if (done) begin
					if (run_active && exp_pix.size() == 0) begin
						run_active = 1'b0;
						run_done   = 1'b1;
					end else begin
						check_done(1'b0, done);	// early or spurious
					end
				end
				if (rsp_cnt > 0) begin
					rsp_cnt--;
					if (rsp_cnt == 0) begin
						rsp_valid <= 1'b1;
						rsp_data  <= rd_data;
					end
				end
				if (mem_valid && mem_ready) begin
					if (!run_active && (mem_req.we || mem_req.addr != CONFIG_BASE))
						fail_run("request other than a start word poll while idle");
					if (mem_req.we) begin
						if (exp_pix.size() == 0)
							fail_run("write that was not expected");
						check_write(exp_addr.pop_front(), exp_pix.pop_front(), mem_req);
						mem[mem_req.addr] = mem_req.wdata;
					end else begin
						if (mem_req.addr == CONFIG_BASE + 1)
							mem[CONFIG_BASE] = 32'd0;	// start word consumed
						rd_data = rd_mem(mem_req.addr);
						rsp_cnt = (stall_mode ? $urandom_range(1, 4) : 1) - 1;
						if (rsp_cnt == 0) begin
							rsp_valid <= 1'b1;
							rsp_data  <= rd_data;
						end
					end
				end
				mem_ready <= stall_mode ? ($urandom_range(0, 3) != 0) : 1'b1;
			end
		end
	end

	initial begin
		logic [3:0]  kind;
		logic [31:0] addr, data, dims;
		int          total;
		clk         = 1'b0;
		rst_n       = 1'b0;
		mem_ready   = 1'b0;
		rsp_valid   = 1'b0;
		rsp_data    = 32'd0;
		run_active  = 1'b0;
		run_done    = 1'b0;
		stall_mode  = 1'b0;
		was_stalled = 1'b0;
		rsp_cnt     = 0;
		total       = 0;
		dims        = 32'd0;
		$readmemh("conv_testdata.txt", recs);
		for (int i = 0; i < 64 && recs[i][67:64] != 4'hf; i++) begin
			if (recs[i][67:64] == 4'h1 && recs[i][63:32] == CONFIG_BASE + 1)
				dims = recs[i][31:0];
			if (recs[i][67:64] == 4'h3)
				total = total + int'(dims[31:16]) * int'(dims[15:0]);
		end
		fork
			begin
				#((10 * total + 2000) * 100);
				fail_run("timeout, no done arrived from the engine");
			end
		join_none
		repeat (4) @(posedge clk);
		rst_n <= 1'b1;
		for (int i = 0; i < 64 && recs[i][67:64] != 4'hf; i++) begin
			kind = recs[i][67:64];
			addr = recs[i][63:32];
			data = recs[i][31:0];
			@(negedge clk);
			case (kind)
				4'h1: mem[addr] = data;
				4'h2: for (int n = 0; n < int'(data); n++)
					mem[addr + n] = {24'd0, fill_pixel(addr + n)};
				4'h3: begin
					build_expected();
					stall_mode       = data[0];
					run_done         = 1'b0;
					run_active       = 1'b1;
					mem[CONFIG_BASE] = 32'd1;
					wait (run_done);
				end
				4'h4: check_write(addr, pixel_t'(data),
				                  '{addr: addr, we: 1'b1, wdata: rd_mem(addr)});
				default: fail_run("bad record kind in the data file");
			endcase
		end
		$display("TESTS PASSED");
		$finish;
	end

endmodule

// ==== conv_testdata.txt ====
// kind_addr_data: 1 store word, 2 fill data words of pixels from addr,
// 3 run (data bit 0 = random stalls), 4 expected result word, f end
2_00000200_0000001e
1_00000101_00060005
1_00000102_00000200
1_00000103_00000300
1_00000104_00000000
1_00000105_00000001
1_00000106_00000000
3_00000000_00000000
4_00000300_000000a5
4_0000030b_00000054
// large and negative coefficients
1_00000103_00000340
1_00000104_05ff7f80
1_00000105_fe03f010
1_00000106_00000040
3_00000000_00000000
// identity again under stalls
1_00000103_00000380
1_00000104_00000000
1_00000105_00000001
1_00000106_00000000
3_00000000_00000001
4_00000380_000000a5
4_0000038b_00000054
// new dimensions and kernel
2_00000400_00000036
1_00000101_00090006
1_00000102_00000400
1_00000103_00000500
1_00000104_02010201
1_00000105_02010204
1_00000106_00000001
3_00000000_00000001
f_00000000_00000000

// ==== sim.f ====
conv_pkg.sv
conv_config_loader.sv
conv_controller.sv
line_buffer.sv
filter_mac.sv
conv_top.sv
tb_conv.sv

// ==== run_sim.sh ====
#!/bin/sh
# builds and runs the convolution engine testbench
set -e
cd "$(dirname "$0")"
verilator --binary --timing -Wno-fatal --top-module tb_conv -f sim.f -o tb_conv
./obj_dir/tb_conv
